// File: source/gemm_pkg.sv
// ====================================================================
// Shared definitions for the integer GEMM engine
//   Array sizes and element and accumulator widths
//   Command opcodes with header and data views of a command word
//   Structs for tile writes, run requests and tile results
// ====================================================================

package gemm_pkg;

    // ================================================================
    // Sizes
    // ================================================================
    localparam int NUM_TILES      = 4;   // Compute tiles
    localparam int TILE_ID_W      = 2;   // Tile index width
    localparam int ELEM_W         = 8;   // Signed operand element
    localparam int ELEMS_PER_WORD = 4;   // Elements per 32-bit word
    localparam int VEC_DEPTH      = 16;  // Words per operand memory
    localparam int VEC_ADDR_W     = 4;
    localparam int VEC_LEN_W      = 5;   // Covers 0 to VEC_DEPTH words
    localparam int ACC_W          = 32;  // Accumulator and result

    typedef enum logic [3:0] {
        OP_NOP        = 4'h0,
        OP_LOAD_LEFT  = 4'h1,   // Broadcast to every tile
        OP_LOAD_RIGHT = 4'h2,   // Into one tile only
        OP_MATMUL     = 4'h3
    } cmd_op_e;

    // Header view of a command word
    typedef struct packed {
        logic [7:0] rsvd;
        logic [7:0] mask;       // Column enable, low NUM_TILES bits
        logic [7:0] len;        // Word count, clamped to VEC_DEPTH
        logic [3:0] tile;       // Target tile, low TILE_ID_W bits
        cmd_op_e    opcode;
    } cmd_hdr_t;

    typedef logic signed [ELEM_W-1:0] elem_t;

    // Data view of a command word, element 0 in the low byte
    typedef struct packed {
        elem_t [ELEMS_PER_WORD-1:0] elem;
    } cmd_data_t;

    typedef union packed {
        cmd_hdr_t  hdr;
        cmd_data_t data;
    } cmd_word_u;

    typedef struct packed {
        logic                  wr_left;   // Left write to all tiles
        logic [NUM_TILES-1:0]  wr_right;  // Right write per tile
        logic [VEC_ADDR_W-1:0] addr;
        cmd_data_t             data;
    } tile_wr_t;

    typedef struct packed {
        logic [NUM_TILES-1:0] start;      // One-cycle start pulse per tile
        logic [VEC_LEN_W-1:0] len;
    } tile_run_t;

    typedef struct packed {
        logic [TILE_ID_W-1:0] tile_id;
        logic [ACC_W-1:0]     value;
    } result_t;

endpackage : gemm_pkg

// File: source/command_sequencer.sv
// ====================================================================
// Command sequencer
//   Decodes host headers and counts the data words of each load
//   Turns data words into left broadcast or right per-tile writes
//   Issues MATMUL run pulses and stalls commands until batch done
// ====================================================================

`timescale 1ns/10ps

module command_sequencer (
    input  logic                i_clk,
    input  logic                i_rst_n,
    // Host command stream
    input  logic                i_cmd_valid,
    input  gemm_pkg::cmd_word_u i_cmd_word,
    output logic                o_cmd_ready,
    // Tile side
    output gemm_pkg::tile_wr_t  o_wr,
    output gemm_pkg::tile_run_t o_run,
    input  logic                i_batch_done   // From result collector
);
    import gemm_pkg::*;

    typedef enum logic [1:0] {
        ST_IDLE,    // Waiting for a header
        ST_LOAD,    // Taking data words
        ST_WAIT     // MATMUL in flight
    } seq_state_e;

    seq_state_e           state_q;
    logic                 cmd_fire;      // Word accepted this cycle
    cmd_hdr_t             hdr;
    logic [VEC_LEN_W-1:0] hdr_len;       // Clamped header length
    logic [VEC_LEN_W-1:0] len_q;         // Words in current load
    logic [VEC_LEN_W-1:0] cnt_q;         // Offset of next data word
    logic                 load_left_q;
    logic [TILE_ID_W-1:0] tile_q;        // Right load target
    logic                 empty_run_q;   // MATMUL with no column set

    // Registered tile write and run request
    logic                  wr_left_q;
    logic [NUM_TILES-1:0]  wr_right_q;
    logic [VEC_ADDR_W-1:0] wr_addr_q;
    cmd_data_t             wr_data_q;
    logic [NUM_TILES-1:0]  run_start_q;
    logic [VEC_LEN_W-1:0]  run_len_q;

    assign o_cmd_ready = (state_q != ST_WAIT);
    assign cmd_fire    = i_cmd_valid && o_cmd_ready;
    assign hdr         = i_cmd_word.hdr;
    assign hdr_len     = (hdr.len > 8'(VEC_DEPTH)) ? VEC_LEN_W'(VEC_DEPTH)
                                                   : hdr.len[VEC_LEN_W-1:0];

    // ================================================================
    // Control FSM
    // ================================================================
    always_ff @(posedge i_clk) begin
        if (!i_rst_n) begin
            state_q     <= ST_IDLE;
            len_q       <= '0;
            cnt_q       <= '0;
            load_left_q <= 1'b0;
            tile_q      <= '0;
            empty_run_q <= 1'b0;
            wr_left_q   <= 1'b0;
            wr_right_q  <= '0;
            run_start_q <= '0;
            run_len_q   <= '0;
        end else begin
            wr_left_q   <= 1'b0;                  // Strobes last one cycle
            wr_right_q  <= '0;
            run_start_q <= '0;
            case (state_q)
                ST_IDLE: if (cmd_fire) begin
                    case (hdr.opcode)
                        OP_LOAD_LEFT, OP_LOAD_RIGHT: begin
                            load_left_q <= (hdr.opcode == OP_LOAD_LEFT);
                            tile_q      <= hdr.tile[TILE_ID_W-1:0];
                            len_q       <= hdr_len;
                            cnt_q       <= '0;
                            if (hdr_len != '0) state_q <= ST_LOAD;  // Empty load ends here
                        end
                        OP_MATMUL: begin
                            run_start_q <= hdr.mask[NUM_TILES-1:0];
                            run_len_q   <= hdr_len;
                            empty_run_q <= (hdr.mask[NUM_TILES-1:0] == '0);
                            state_q     <= ST_WAIT;
                        end
                        default: ;                // NOP and unknown opcodes dropped
                    endcase
                end
                ST_LOAD: if (cmd_fire) begin
                    wr_left_q  <= load_left_q;
                    wr_right_q <= load_left_q ? '0 : (NUM_TILES'(1) << tile_q);
                    cnt_q      <= cnt_q + 1'b1;
                    if (cnt_q + 1'b1 == len_q) state_q <= ST_IDLE;  // Last data word
                end
                // An empty mask has no tile to wait for
                ST_WAIT: if (i_batch_done || empty_run_q) state_q <= ST_IDLE;
                default: state_q <= ST_IDLE;
            endcase
        end
    end

    // Write address and data follow the accepted word
    always_ff @(posedge i_clk) begin
        if (state_q == ST_LOAD && cmd_fire) begin
            wr_addr_q <= cnt_q[VEC_ADDR_W-1:0];   // Offset within the load
            wr_data_q <= i_cmd_word.data;
        end
    end

    assign o_wr  = '{wr_left: wr_left_q, wr_right: wr_right_q,
                     addr: wr_addr_q, data: wr_data_q};
    assign o_run = '{start: run_start_q, len: run_len_q};

endmodule : command_sequencer

// File: source/dot_tile.sv
// ====================================================================
// Compute tile
//   Private left and right operand memories
//   Walks the first len words and accumulates signed element products
//   Holds the sum under valid/ready until the collector takes it
// ====================================================================

`timescale 1ns/10ps

module dot_tile (
    input  logic                           i_clk,
    input  logic                           i_rst_n,
    input  gemm_pkg::tile_wr_t             i_wr,
    input  logic                           i_tile_sel,   // This tile's right write bit
    input  logic                           i_start,
    input  logic [gemm_pkg::VEC_LEN_W-1:0] i_len,
    output logic                           o_res_valid,
    output logic [gemm_pkg::ACC_W-1:0]     o_res_value,
    input  logic                           i_res_ready
);
    import gemm_pkg::*;

    cmd_data_t left_mem  [VEC_DEPTH];
    cmd_data_t right_mem [VEC_DEPTH];

    logic                       busy_q;      // Issuing reads
    logic [VEC_LEN_W-1:0]       cnt_q;       // Reads left to issue
    logic [VEC_ADDR_W-1:0]      rd_addr_q;
    logic                       rd_vld_q;    // Operand pair ready this cycle
    logic                       fin_q;       // Final accumulate this cycle
    cmd_data_t                  left_q;
    cmd_data_t                  right_q;
    logic signed [2*ELEM_W-1:0] prod [ELEMS_PER_WORD];
    logic signed [ACC_W-1:0]    dot;         // Sum of one word's products
    logic signed [ACC_W-1:0]    acc_q;

    // Operand writes
    always_ff @(posedge i_clk) begin
        if (i_wr.wr_left) left_mem[i_wr.addr] <= i_wr.data;
        if (i_tile_sel)   right_mem[i_wr.addr] <= i_wr.data;
    end

    always_ff @(posedge i_clk) begin
        left_q  <= left_mem[rd_addr_q];     // Registered read
        right_q <= right_mem[rd_addr_q];
    end

    // Read sequencing
    always_ff @(posedge i_clk) begin
        if (!i_rst_n) begin
            busy_q    <= 1'b0;
            cnt_q     <= '0;
            rd_addr_q <= '0;
            rd_vld_q  <= 1'b0;
            fin_q     <= 1'b0;
        end else begin
            rd_vld_q <= busy_q;
            fin_q    <= (busy_q && cnt_q == VEC_LEN_W'(1)) || (i_start && i_len == '0);
            if (i_start) begin
                busy_q    <= (i_len != '0);
                cnt_q     <= i_len;
                rd_addr_q <= '0;
            end else if (busy_q) begin
                rd_addr_q <= rd_addr_q + 1'b1;
                cnt_q     <= cnt_q - 1'b1;
                if (cnt_q == VEC_LEN_W'(1)) busy_q <= 1'b0;  // Last read issued
            end
        end
    end

    always_comb begin
        dot = '0;
        for (int i = 0; i < ELEMS_PER_WORD; i++) begin
            prod[i] = $signed(left_q.elem[i]) * $signed(right_q.elem[i]);
            dot     = dot + prod[i];                          // Sign-extended sum
        end
    end

    always_ff @(posedge i_clk) begin
        if (i_start)       acc_q <= '0;
        else if (rd_vld_q) acc_q <= acc_q + dot;
    end

    // Result handshake
    always_ff @(posedge i_clk) begin
        if (!i_rst_n)                        o_res_valid <= 1'b0;
        else if (fin_q)                      o_res_valid <= 1'b1;
        else if (o_res_valid && i_res_ready) o_res_valid <= 1'b0;  // Taken
    end

    assign o_res_value = acc_q;

endmodule : dot_tile

// File: source/result_collector.sv
// ====================================================================
// Result collector
//   Latches the column mask of each run
//   Forwards pending tile results in ascending tile order
//   Pulses batch done after the last transfer
// ====================================================================

`timescale 1ns/10ps

module result_collector (
    input  logic                           i_clk,
    input  logic                           i_rst_n,
    input  gemm_pkg::tile_run_t            i_run,
    // Tile results
    input  logic [gemm_pkg::NUM_TILES-1:0] i_tile_valid,
    input  logic [gemm_pkg::ACC_W-1:0]     i_tile_value [gemm_pkg::NUM_TILES],
    output logic [gemm_pkg::NUM_TILES-1:0] o_tile_ready,
    // Host result port
    output logic                           o_res_valid,
    output gemm_pkg::result_t              o_res,
    input  logic                           i_res_ready,
    output logic                           o_batch_done
);
    import gemm_pkg::*;

    logic [NUM_TILES-1:0] pending_q;     // Tiles still owed this run
    logic [TILE_ID_W-1:0] ptr;           // Lowest pending tile
    logic [NUM_TILES-1:0] ptr_onehot;
    logic [NUM_TILES-1:0] pending_nxt;   // Pending after this transfer
    logic                 xfer;

    always_comb begin
        ptr = '0;
        for (int t = NUM_TILES - 1; t >= 0; t--) begin
            if (pending_q[t]) ptr = TILE_ID_W'(t);   // Lowest id wins
        end
    end

    assign ptr_onehot  = NUM_TILES'(1) << ptr;
    assign pending_nxt = pending_q & ~ptr_onehot;

    // Host side handshake
    assign o_res_valid  = pending_q[ptr] && i_tile_valid[ptr];
    assign o_res        = '{tile_id: ptr, value: i_tile_value[ptr]};
    assign xfer         = o_res_valid && i_res_ready;
    assign o_tile_ready = (pending_q[ptr] && i_res_ready) ? ptr_onehot : '0;

    always_ff @(posedge i_clk) begin
        if (!i_rst_n) begin
            pending_q    <= '0;
            o_batch_done <= 1'b0;
        end else begin
            o_batch_done <= xfer && (pending_nxt == '0);   // Last result out
            if (i_run.start != '0) pending_q <= i_run.start;
            else if (xfer)         pending_q <= pending_nxt;
        end
    end

endmodule : result_collector

// File: source/gemm_engine_top.sv
// ====================================================================
// Integer GEMM engine top level
//   Command sequencer feeding NUM_TILES dot-product tiles
//   Result collector draining the tiles to the host port
// ====================================================================

`timescale 1ns/10ps

module gemm_engine_top (
    input  logic                i_clk,
    input  logic                i_rst_n,
    // Host command stream
    input  logic                i_cmd_valid,
    input  gemm_pkg::cmd_word_u i_cmd_word,
    output logic                o_cmd_ready,
    // Host result stream
    output logic                o_res_valid,
    output gemm_pkg::result_t   o_res,
    input  logic                i_res_ready
);
    import gemm_pkg::*;

    tile_wr_t             wr;            // Operand writes to all tiles
    tile_run_t            run;           // Start pulse and length
    logic                 batch_done;
    logic [NUM_TILES-1:0] tile_valid;
    logic [NUM_TILES-1:0] tile_ready;
    logic [ACC_W-1:0]     tile_value [NUM_TILES];

    command_sequencer u_command_sequencer (
        .i_clk        (i_clk),
        .i_rst_n      (i_rst_n),
        .i_cmd_valid  (i_cmd_valid),
        .i_cmd_word   (i_cmd_word),
        .o_cmd_ready  (o_cmd_ready),
        .o_wr         (wr),
        .o_run        (run),
        .i_batch_done (batch_done)
    );

    // ================================================================
    // Tile array
    // ================================================================
    for (genvar t = 0; t < NUM_TILES; t++) begin : g_tile
        dot_tile u_dot_tile (
            .i_clk       (i_clk),
            .i_rst_n     (i_rst_n),
            .i_wr        (wr),
            .i_tile_sel  (wr.wr_right[t]),   // Own right write bit
            .i_start     (run.start[t]),     // Own column enable
            .i_len       (run.len),
            .o_res_valid (tile_valid[t]),
            .o_res_value (tile_value[t]),
            .i_res_ready (tile_ready[t])
        );
    end

    result_collector u_result_collector (
        .i_clk        (i_clk),
        .i_rst_n      (i_rst_n),
        .i_run        (run),
        .i_tile_valid (tile_valid),
        .i_tile_value (tile_value),
        .o_tile_ready (tile_ready),
        .o_res_valid  (o_res_valid),
        .o_res        (o_res),
        .i_res_ready  (i_res_ready),
        .o_batch_done (batch_done)
    );

endmodule : gemm_engine_top

// File: verif/gemm_engine_assertions.sv
// ======================================================================
// Handshake assertions bound to the GEMM engine top level
//   Result hold under back-pressure and quiet port after reset
//   Results only while the command port stalls
//   Tally of failed assertions
// ======================================================================

`timescale 1ns/10ps

module gemm_engine_assertions (
    input logic              i_clk,
    input logic              i_rst_n,
    input logic              o_cmd_ready,
    input logic              o_res_valid,
    input gemm_pkg::result_t o_res,
    input logic              i_res_ready
);

    int fail_count = 0;    // Failed assertions so far

    // Offered result stays put until the host takes it
    a_res_hold: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        o_res_valid && !i_res_ready |=> o_res_valid && $stable(o_res))
        else begin
            $error("Result changed or dropped under back-pressure");
            fail_count++;
        end

    a_quiet_after_reset: assert property (@(posedge i_clk)
        !i_rst_n |=> !o_res_valid)
        else begin
            $error("Result valid in the cycle after reset");
            fail_count++;
        end

    // Results flow only inside a MATMUL stall
    a_no_res_when_ready: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        o_cmd_ready |-> !o_res_valid)
        else begin
            $error("Result valid while commands are accepted");
            fail_count++;
        end

    a_stall_held: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        !o_cmd_ready && o_res_valid |=> !o_cmd_ready)
        else begin
            $error("Command ready rose before the batch drained");
            fail_count++;
        end

endmodule : gemm_engine_assertions

bind gemm_engine_top gemm_engine_assertions u_gemm_engine_assertions (.*);

// File: verif/tb_gemm_engine.sv
// ======================================================================
// Testbench for the integer GEMM engine
//   Clock, reset and LCG stimulus driven on the falling edge
//   Model copy of the left and right vectors with a reference dot product
//   Comparing process on the result port and closing error report
// ======================================================================

`timescale 1ns/10ps

module tb_gemm_engine;
    import gemm_pkg::*;

    localparam int WAIT_LIMIT  = 200;    // Cycles per command word
    localparam int DRAIN_LIMIT = 2000;   // Cycles to drain a batch

    logic              clk;
    logic              rst_n;
    logic              cmd_valid;
    cmd_word_u         cmd_word;
    logic              cmd_ready;
    logic              res_valid;
    result_t           res;
    logic              res_ready;

    logic [31:0]       left_mdl  [VEC_DEPTH];              // Broadcast vector copy
    logic [31:0]       right_mdl [NUM_TILES][VEC_DEPTH];   // Per-tile copies
    result_t           exp_q [$];                          // Expected in host order
    logic [31:0]       data_lcg;
    logic [31:0]       ready_lcg;                          // Separate stream for ready
    logic              rand_ready;
    int                err_value;
    int                err_unexpected;
    int                err_timeout;
    int                err_assert;                         // Bound handshake checks

    gemm_engine_top gemm_engine_top_inst (
        .i_clk       (clk),
        .i_rst_n     (rst_n),
        .i_cmd_valid (cmd_valid),
        .i_cmd_word  (cmd_word),
        .o_cmd_ready (cmd_ready),
        .o_res_valid (res_valid),
        .o_res       (res),
        .i_res_ready (res_ready)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;                             // 10 ns period
    end

    // ==================================================================
    // Stimulus helpers
    // ==================================================================
    function automatic logic [31:0] lcg_step(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    function automatic cmd_word_u make_hdr(input cmd_op_e op, input int tile,
                                           input int len, input int mask);
        cmd_word_u w;
        w            = '0;
        w.hdr.opcode = op;
        w.hdr.tile   = 4'(tile);
        w.hdr.len    = 8'(len);
        w.hdr.mask   = 8'(mask);
        return w;
    endfunction

    // Expected dot product over the first len words of one tile
    function automatic logic [31:0] ref_dot(input int tile, input int len);
        int  acc;
        int  n;
        byte lb;
        byte rb;
        acc = 0;
        n   = (len > VEC_DEPTH) ? VEC_DEPTH : len;
        for (int a = 0; a < n; a++) begin
            for (int e = 0; e < ELEMS_PER_WORD; e++) begin
                lb  = left_mdl[a][8*e +: 8];
                rb  = right_mdl[tile][a][8*e +: 8];
                acc = acc + int'(lb) * int'(rb);           // Signed 8x8 products
            end
        end
        return 32'(acc);
    endfunction

    // Called on a falling edge, returns on the falling edge after the transfer
    task automatic send_word(input cmd_word_u w);
        int waited;
        waited    = 0;
        cmd_valid = 1'b1;
        cmd_word  = w;
        while (!cmd_ready && waited < WAIT_LIMIT) begin
            @(negedge clk);
            waited++;
        end
        assert (cmd_ready) else begin
            $display("Command port stayed stalled for %0d cycles", WAIT_LIMIT);
            err_timeout++;
        end
        @(negedge clk);                                    // Handshake on the rising edge
        cmd_valid = 1'b0;
    endtask

    task automatic load_left(input int len);
        cmd_word_u d;
        send_word(make_hdr(OP_LOAD_LEFT, 0, len, 0));
        for (int a = 0; a < len; a++) begin
            data_lcg    = lcg_step(data_lcg);
            left_mdl[a] = data_lcg;
            d           = data_lcg;
            send_word(d);
        end
    endtask

    task automatic load_right(input int tile, input int len);
        cmd_word_u d;
        send_word(make_hdr(OP_LOAD_RIGHT, tile, len, 0));
        for (int a = 0; a < len; a++) begin
            data_lcg             = lcg_step(data_lcg);
            right_mdl[tile][a]   = data_lcg;
            d                    = data_lcg;
            send_word(d);
        end
    endtask

    // Queue one result per enabled column, ascending id, then issue the run
    task automatic run_matmul(input int len, input int mask);
        result_t e;
        for (int t = 0; t < NUM_TILES; t++) begin
            if (mask[t]) begin
                e.tile_id = TILE_ID_W'(t);
                e.value   = ref_dot(t, len);
                exp_q.push_back(e);
            end
        end
        send_word(make_hdr(OP_MATMUL, 0, len, mask));
    endtask

    task automatic wait_drain();
        int waited;
        waited = 0;
        while (exp_q.size() != 0 && waited < DRAIN_LIMIT) begin
            @(negedge clk);
            waited++;
        end
        assert (exp_q.size() == 0) else begin
            $display("Results still missing after timeout, %0d outstanding", exp_q.size());
            err_timeout++;
            exp_q.delete();
        end
    endtask

    // Host ready, random while rand_ready is set
    initial begin
        forever begin
            @(negedge clk);
            ready_lcg = lcg_step(ready_lcg);
            res_ready = rand_ready ? (ready_lcg[31:30] != 2'b00) : 1'b1;
        end
    end

    // ==================================================================
    // Comparing process
    // ==================================================================
    always @(posedge clk) begin
        result_t e;
        if (rst_n && res_valid && res_ready) begin
            assert (exp_q.size() != 0) else begin
                $display("Result from tile %0d arrived with none expected", res.tile_id);
                err_unexpected++;
            end
            if (exp_q.size() != 0) begin
                e = exp_q.pop_front();
                assert (res.tile_id == e.tile_id) else begin
                    $display("ERROR o_res.tile_id got 0x%0h expected 0x%0h",
                             res.tile_id, e.tile_id);
                    err_value++;
                end
                assert (res.value == e.value) else begin
                    $display("ERROR o_res.value got 0x%08h expected 0x%08h",
                             res.value, e.value);
                    err_value++;
                end
            end
        end
    end

    // ==================================================================
    // Test sequence
    // ==================================================================
    initial begin
        rst_n          = 1'b0;
        cmd_valid      = 1'b0;
        cmd_word       = '0;
        res_ready      = 1'b0;
        rand_ready     = 1'b0;
        data_lcg       = 32'h1308_7682;
        ready_lcg      = 32'h1308_7682;
        err_value      = 0;
        err_unexpected = 0;
        err_timeout    = 0;
        err_assert     = 0;
        repeat (2) @(negedge clk);                         // Two reset cycles
        rst_n = 1'b1;
        @(negedge clk);

        // Broadcast left, one right per tile, all columns
        load_left(VEC_DEPTH);
        for (int t = 0; t < NUM_TILES; t++) load_right(t, VEC_DEPTH);
        run_matmul(VEC_DEPTH, 4'hF);
        wait_drain();

        // Partial mask, zero mask, then a NOP and another run
        run_matmul(8, 4'b1010);
        wait_drain();
        run_matmul(8, 4'b0000);
        send_word(make_hdr(OP_NOP, 0, 0, 0));
        run_matmul(4, 4'b0101);
        wait_drain();

        // Back-to-back runs under random host back-pressure
        rand_ready = 1'b1;
        for (int i = 0; i < 6; i++) begin
            data_lcg = lcg_step(data_lcg);
            run_matmul(int'(data_lcg[23:16]) % (VEC_DEPTH + 1), int'(data_lcg[27:24]));
        end
        wait_drain();
        rand_ready = 1'b0;

        // Short and empty lengths
        run_matmul(5, 4'hF);
        run_matmul(0, 4'hF);
        wait_drain();

        // Reload one right vector, only tile 2 changes
        load_right(2, VEC_DEPTH);
        run_matmul(VEC_DEPTH, 4'hF);
        wait_drain();

        repeat (10) @(negedge clk);                        // Catch stray results
        err_assert = gemm_engine_top_inst.u_gemm_engine_assertions.fail_count;
        $display("Errors: %0d value, %0d unexpected, %0d timeout, %0d assertion",
                 err_value, err_unexpected, err_timeout, err_assert);
        if (err_value + err_unexpected + err_timeout + err_assert == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

endmodule : tb_gemm_engine

// File: sources.f
source/gemm_pkg.sv
source/command_sequencer.sv
source/dot_tile.sv
source/result_collector.sv
source/gemm_engine_top.sv
verif/gemm_engine_assertions.sv
verif/tb_gemm_engine.sv

// File: Bender.yml
package:
  name: gemm_engine

sources:
  - files:
      - source/gemm_pkg.sv
      - source/command_sequencer.sv
      - source/dot_tile.sv
      - source/result_collector.sv
      - source/gemm_engine_top.sv
  - target: test
    files:
      - verif/gemm_engine_assertions.sv
      - verif/tb_gemm_engine.sv
